// ==== common/cpu_cfg.svh ====
// fixed core configuration; changing the register count also changes the instruction field widths
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and address width, instruction words use the same width
`define CPU_XLEN 16

// architectural registers, r0 reads as zero
`define CPU_NREGS 16

// address of the first fetch after reset
`define CPU_RESET_PC 16'h0000

`endif

// ==== common/cpu_pkg.sv ====
// pipeline types; opcodes 4'hc to 4'hf have no enum name and run as no-operation
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // bits 3:0 of every instruction word
    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_and = 4'h2,
        op_or  = 4'h3,
        op_xor = 4'h4,
        op_shl = 4'h5,
        op_shr = 4'h6,
        op_li  = 4'h7,
        op_lw  = 4'h8,
        op_sw  = 4'h9,
        op_bz  = 4'ha,
        op_jr  = 4'hb
    } opcode_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        // li value or branch offset
        logic [7:0] imm;
        logic     reg_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        // alu result, or address for lw/sw
        word_t    result;
        word_t    store_data;
        logic     reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
    } mem_wb_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        word_t    adr;
        word_t    dat;
    } wb_req_t;

    typedef struct packed {
        word_t    dat;
        logic     ack;
    } wb_rsp_t;

endpackage

// ==== pipeline/fetch_stage.sv ====
// instruction port has no handshake, imem_data must be valid in the cycle imem_addr is driven
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module fetch_stage (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             mem_busy,
    input  logic             hazard_stall,
    input  logic             redirect,
    input  cpu_pkg::word_t   redirect_pc,
    output cpu_pkg::word_t   imem_addr,
    input  cpu_pkg::word_t   imem_data,
    output cpu_pkg::if_id_t  if_id
);
    import cpu_pkg::*;

    word_t pc_q;
    logic  valid_q;
    word_t pc_id_q;
    word_t instr_q;
    logic  advance;

    // a memory access freezes everything, a redirect beats the load-use hold
    assign advance = !mem_busy && !redirect && !hazard_stall;

    assign imem_addr = pc_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc_q    <= `CPU_RESET_PC;
            valid_q <= 1'b0;
        end else if (!mem_busy) begin
            if (redirect) begin
                // word being fetched now is on the wrong path
                pc_q    <= redirect_pc;
                valid_q <= 1'b0;
            end else if (!hazard_stall) begin
                pc_q    <= pc_q + 1'b1;
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            pc_id_q <= pc_q;
            instr_q <= imem_data;
        end
    end

    assign if_id = '{valid: valid_q, pc: pc_id_q, instr: instr_q};

endmodule

// ==== pipeline/decode_stage.sv ====
// register file has no reset, software must write a register before reading it
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module decode_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              mem_busy,
    input  logic              redirect,
    input  cpu_pkg::if_id_t   if_id,
    input  cpu_pkg::mem_wb_t  mem_wb,
    input  cpu_pkg::reg_idx_t ex_load_rd,
    output logic              hazard_stall,
    output cpu_pkg::id_ex_t   id_ex
);
    import cpu_pkg::*;

    word_t      regs [`CPU_NREGS];
    opcode_t    op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [7:0] imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    logic       valid_q;

    // r0 is hardwired, a writeback in this cycle is seen by the read
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored,
                                        input mem_wb_t wb);
        if (idx == '0) begin
            return '0;
        end
        if (wb.valid && wb.reg_write && wb.rd == idx) begin
            return wb.result;
        end
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (mem_wb.valid && mem_wb.reg_write) begin
            regs[mem_wb.rd] <= mem_wb.result;
        end
    end

    // field split: op 3:0, rd 7:4, rs1 11:8, rs2 15:12
    always_comb begin
        op        = opcode_t'(if_id.instr[3:0]);
        rd        = if_id.instr[7:4];
        rs1       = if_id.instr[11:8];
        rs2       = if_id.instr[15:12];
        imm       = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            op_li: begin
                imm       = if_id.instr[15:8];
                writes_rd = 1'b1;
            end
            op_lw: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            op_sw: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_bz: begin
                // offset is split around the rs1 field
                imm      = {if_id.instr[15:12], if_id.instr[7:4]};
                uses_rs1 = 1'b1;
            end
            op_jr: begin
                uses_rs1 = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // load in execute, its data is not ready for a direct consumer
    assign hazard_stall = if_id.valid && (ex_load_rd != '0) &&
                          ((uses_rs1 && rs1 == ex_load_rd) ||
                           (uses_rs2 && rs2 == ex_load_rd));

    always_comb begin
        id_ex_d.valid     = if_id.valid && !redirect && !hazard_stall;
        id_ex_d.opcode    = op;
        id_ex_d.pc        = if_id.pc;
        id_ex_d.rs1       = rs1;
        id_ex_d.rs2       = rs2;
        id_ex_d.rd        = rd;
        id_ex_d.a         = read_port(rs1, regs[rs1], mem_wb);
        id_ex_d.b         = read_port(rs2, regs[rs2], mem_wb);
        id_ex_d.imm       = imm;
        id_ex_d.reg_write = writes_rd && (rd != '0);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!mem_busy) begin
            valid_q <= id_ex_d.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!mem_busy) begin
            id_ex_q <= id_ex_d;
        end
    end

    always_comb begin
        id_ex       = id_ex_q;
        id_ex.valid = valid_q;
    end

endmodule

// ==== pipeline/execute_stage.sv ====
// branches resolve here, so a taken bz or jr costs two flushed slots
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module execute_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              mem_busy,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::mem_wb_t  mem_wb,
    output cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::reg_idx_t ex_load_rd,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc
);
    import cpu_pkg::*;

    word_t   opa;
    word_t   opb;
    word_t   alu_result;
    word_t   branch_offset;
    word_t   branch_target;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    valid_q;

    // newest producer wins: ex_mem first, then mem_wb, else the decode read
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val,
                                      input ex_mem_t em, input mem_wb_t wb);
        if (em.valid && em.reg_write && em.rd == idx) begin
            return em.result;
        end
        if (wb.valid && wb.reg_write && wb.rd == idx) begin
            return wb.result;
        end
        return reg_val;
    endfunction

    assign opa = forward(id_ex.rs1, id_ex.a, ex_mem_q, mem_wb);
    assign opb = forward(id_ex.rs2, id_ex.b, ex_mem_q, mem_wb);

    always_comb begin
        case (id_ex.opcode)
            op_add:  alu_result = opa + opb;
            op_sub:  alu_result = opa - opb;
            op_and:  alu_result = opa & opb;
            op_or:   alu_result = opa | opb;
            op_xor:  alu_result = opa ^ opb;
            op_shl:  alu_result = opa << opb[3:0];
            op_shr:  alu_result = opa >> opb[3:0];
            op_li:   alu_result = {{(`CPU_XLEN-8){1'b0}}, id_ex.imm};
            // word address for loads and stores
            op_lw:   alu_result = opa;
            op_sw:   alu_result = opa;
            default: alu_result = '0;
        endcase
    end

    assign branch_offset = {{(`CPU_XLEN-8){id_ex.imm[7]}}, id_ex.imm};
    assign branch_target = id_ex.pc + 1'b1 + branch_offset;

    assign redirect = id_ex.valid &&
                      ((id_ex.opcode == op_bz && opa == '0) || id_ex.opcode == op_jr);
    assign redirect_pc = (id_ex.opcode == op_jr) ? opa : branch_target;

    // zero means no load, a load into r0 never stalls anyone
    assign ex_load_rd = (id_ex.valid && id_ex.opcode == op_lw) ? id_ex.rd : '0;

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.opcode     = id_ex.opcode;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.result     = alu_result;
        ex_mem_d.store_data = opb;
        ex_mem_d.reg_write  = id_ex.reg_write;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!mem_busy) begin
            valid_q <= ex_mem_d.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!mem_busy) begin
            ex_mem_q <= ex_mem_d;
        end
    end

    always_comb begin
        ex_mem       = ex_mem_q;
        ex_mem.valid = valid_q;
    end

endmodule

// ==== pipeline/memory_stage.sv ====
// one wishbone classic transfer per lw/sw, cyc drops for a cycle between transfers
`timescale 1ns/10ps

module memory_stage (
    input  logic             clock,
    input  logic             arst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::wb_rsp_t wb_rsp,
    output logic             mem_busy,
    output cpu_pkg::mem_wb_t mem_wb
);
    import cpu_pkg::*;

    typedef enum logic {
        st_idle,
        st_access
    } state_t;

    state_t  state_q;
    logic    is_mem;
    logic    done;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    logic    valid_q;

    assign is_mem = ex_mem.valid && (ex_mem.opcode == op_lw || ex_mem.opcode == op_sw);
    assign done   = (state_q == st_access) && wb_rsp.ack;

    // whole pipeline waits until the slave acks
    assign mem_busy = is_mem && !done;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (is_mem) begin
                        state_q <= st_access;
                    end
                end
                st_access: begin
                    if (wb_rsp.ack) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // request fields stay put since ex_mem is frozen while busy
    always_comb begin
        wb_req.cyc = (state_q == st_access);
        wb_req.stb = (state_q == st_access);
        wb_req.we  = (state_q == st_access) && (ex_mem.opcode == op_sw);
        wb_req.adr = ex_mem.result;
        wb_req.dat = ex_mem.store_data;
    end

    always_comb begin
        mem_wb_d.valid     = ex_mem.valid;
        mem_wb_d.rd        = ex_mem.rd;
        mem_wb_d.result    = (ex_mem.opcode == op_lw) ? wb_rsp.dat : ex_mem.result;
        mem_wb_d.reg_write = ex_mem.reg_write;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!mem_busy) begin
            valid_q <= mem_wb_d.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!mem_busy) begin
            mem_wb_q <= mem_wb_d;
        end
    end

    always_comb begin
        mem_wb       = mem_wb_q;
        mem_wb.valid = valid_q;
    end

endmodule

// ==== src/cpu_core.sv ====
// word-addressed instruction and data spaces, data only through the wishbone master
`timescale 1ns/10ps

module cpu_core (
    input  logic             clock,
    input  logic             arst_n,
    output cpu_pkg::word_t   imem_addr,
    input  cpu_pkg::word_t   imem_data,
    output cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::wb_rsp_t wb_rsp
);
    import cpu_pkg::*;

    // stage registers
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    // hazard and flush control
    logic     mem_busy;
    logic     hazard_stall;
    logic     redirect;
    word_t    redirect_pc;
    reg_idx_t ex_load_rd;

    fetch_stage u_fetch (
        .clock        (clock),
        .arst_n       (arst_n),
        .mem_busy     (mem_busy),
        .hazard_stall (hazard_stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .if_id        (if_id)
    );

    decode_stage u_decode (
        .clock        (clock),
        .arst_n       (arst_n),
        .mem_busy     (mem_busy),
        .redirect     (redirect),
        .if_id        (if_id),
        .mem_wb       (mem_wb),
        .ex_load_rd   (ex_load_rd),
        .hazard_stall (hazard_stall),
        .id_ex        (id_ex)
    );

    execute_stage u_execute (
        .clock        (clock),
        .arst_n       (arst_n),
        .mem_busy     (mem_busy),
        .id_ex        (id_ex),
        .mem_wb       (mem_wb),
        .ex_mem       (ex_mem),
        .ex_load_rd   (ex_load_rd),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    memory_stage u_memory (
        .clock        (clock),
        .arst_n       (arst_n),
        .ex_mem       (ex_mem),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .mem_busy     (mem_busy),
        .mem_wb       (mem_wb)
    );

endmodule

// ==== testbench/cpu_assertions.sv ====
// wishbone classic master checks, bound into every memory_stage instance
`timescale 1ns/10ps

module cpu_assertions (
    input logic             clock,
    input logic             arst_n,
    input cpu_pkg::wb_req_t wb_req,
    input cpu_pkg::wb_rsp_t wb_rsp
);

    // cycle closes right after the acked transfer
    cyc_ends_after_ack: assert property (@(posedge clock) disable iff (!arst_n)
        (wb_req.stb && wb_rsp.ack) |=> !wb_req.cyc)
        else $error("wishbone cyc still high in the cycle after ack");

    // request held while the slave inserts wait states
    request_stable: assert property (@(posedge clock) disable iff (!arst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)))
        else $error("wishbone request changed before ack");

    ack_needs_stb: assert property (@(posedge clock) disable iff (!arst_n)
        wb_rsp.ack |-> wb_req.stb)
        else $error("wishbone ack without stb");

    idle_in_reset: assert property (@(posedge clock)
        !arst_n |-> !wb_req.cyc)
        else $error("wishbone cyc high during reset");

endmodule

bind memory_stage cpu_assertions u_assertions (
    .clock  (clock),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

// ==== testbench/cpu_checker.sv ====
// compares acked bus writes with an expected list of at most 64 stores, in order
`timescale 1ns/10ps

module cpu_checker (
    input  logic             clock,
    input  logic             arst_n,
    input  cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::wb_rsp_t wb_rsp,
    input  logic [15:0]      exp_adr [64],
    input  logic [15:0]      exp_dat [64],
    input  int               exp_total,
    output int               error_count,
    output int               store_count
);

    always @(posedge clock) begin
        if (!arst_n) begin
            if (wb_req.cyc) begin
                $display("bus cycle started while reset was still asserted at %0t", $time);
                error_count <= error_count + 1;
            end
        end else if (wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
            if (store_count >= exp_total) begin
                // the self-loop at the end must stay silent
                $display("ERROR %0t: unexpected store adr=%h dat=%h", $time,
                         wb_req.adr, wb_req.dat);
                error_count <= error_count + 1;
            end else if (wb_req.adr !== exp_adr[store_count] ||
                         wb_req.dat !== exp_dat[store_count]) begin
                $display("ERROR %0t: store %0d adr=%h dat=%h, expected adr=%h dat=%h",
                         $time, store_count, wb_req.adr, wb_req.dat,
                         exp_adr[store_count], exp_dat[store_count]);
                error_count <= error_count + 1;
            end
            store_count <= store_count + 1;
        end
    end

endmodule

// ==== testbench/cpu_tb.sv ====
// rom and data memory hold 256 words each; the slave adds 0 to 3 random wait states
`timescale 1ns/10ps

module cpu_tb;
    import cpu_pkg::*;

    logic        clock = 1'b0;
    logic        arst_n = 1'b0;
    word_t       imem_addr;
    word_t       imem_data;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        ack_q = 1'b0;
    logic [15:0] rdat_q = 16'h0000;
    logic [1:0]  wait_left = 2'd0;
    logic        counting = 1'b0;
    logic [31:0] rng_q = 32'h5206;

    logic [15:0] rom [256];
    logic [15:0] dmem [256];
    logic [15:0] exp_adr [64];
    logic [15:0] exp_dat [64];
    int          exp_total = 0;
    int          error_count;
    int          store_count;
    int          load_errors = 0;
    int          timeouts = 0;

    always #5 clock = ~clock;

    assign imem_data = rom[imem_addr[7:0]];
    assign wb_rsp = '{dat: rdat_q, ack: ack_q};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // wishbone slave, ack is registered and drops right after one cycle
    always @(posedge clock) begin
        logic [31:0] nxt;
        logic        respond;
        nxt = xorshift(rng_q);
        respond = 1'b0;
        if (!arst_n || ack_q) begin
            ack_q <= 1'b0;
            counting <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!counting) begin
                rng_q <= nxt;
                if (nxt[1:0] == 2'd0) begin
                    respond = 1'b1;
                end else begin
                    wait_left <= nxt[1:0];
                    counting <= 1'b1;
                end
            end else if (wait_left == 2'd1) begin
                respond = 1'b1;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
        if (respond) begin
            ack_q <= 1'b1;
            counting <= 1'b0;
            if (wb_req.we) begin
                dmem[wb_req.adr[7:0]] <= wb_req.dat;
            end else begin
                rdat_q <= dmem[wb_req.adr[7:0]];
            end
        end
    end

    cpu_core UUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    cpu_checker u_checker (
        .clock       (clock),
        .arst_n      (arst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .exp_adr     (exp_adr),
        .exp_dat     (exp_dat),
        .exp_total   (exp_total),
        .error_count (error_count),
        .store_count (store_count)
    );

    task automatic load_testdata();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  kind;
        logic [15:0] a;
        logic [15:0] d;
        // unused rom words decode as opcode c, a no-operation
        for (int i = 0; i < 256; i++) begin
            rom[i] = {i[11:0], 4'hc};
            dmem[i] = i[15:0] ^ 16'ha5a5;
        end
        fd = $fopen("testbench/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%c %h %h", kind, a, d);
                if (got == 3 && kind == "I") begin
                    rom[a[7:0]] = d;
                end else if (got == 3 && kind == "D") begin
                    dmem[a[7:0]] = d;
                end else if (got == 3 && kind == "E" && exp_total < 64) begin
                    exp_adr[exp_total] = a;
                    exp_dat[exp_total] = d;
                    exp_total++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        load_testdata();
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        cycles = 0;
        while (store_count < exp_total && cycles < 3000) begin
            @(posedge clock);
            cycles++;
        end
        if (store_count < exp_total) begin
            $display("timeout, the stores did not finish: %0d of %0d seen",
                     store_count, exp_total);
            timeouts++;
        end else begin
            // quiet window, the self-loop must not write again
            cycles = 0;
            while (cycles < 200) begin
                @(posedge clock);
                cycles++;
            end
        end
        @(posedge clock);
        $display("errors=%0d timeouts=%0d load_errors=%0d stores=%0d of %0d",
                 error_count, timeouts, load_errors, store_count, exp_total);
        if (error_count == 0 && timeouts == 0 && load_errors == 0 && exp_total > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/cpu_testdata.txt ====
# I addr word = instruction rom, D addr word = initial data memory
# E addr data = expected store, in program order
I 00 0517
I 01 0327
I 02 2130
I 03 1341
I 04 40a7
I 05 3a09
I 06 4354
I 07 2565
I 08 1673
I 09 2786
I 0a 3792
I 0b 89b0
I 0c 41c7
I 0d bc09
I 0e 5017
I 0f 0128
I 10 2230
I 11 4247
I 12 3409
I 13 5167
I 14 0678
I 15 0187
I 16 8790
I 17 4347
I 18 9409
I 19 092a
I 1a 44a7
I 1b 1a09
I 1c 003a
I 1d 9a09
I 1e 9a09
I 1f 9a09
I 20 45b7
I 21 3b09
I 22 27c7
I 23 0c0b
I 24 9a09
I 25 9a09
I 26 9a09
I 27 46d7
I 28 7d09
I 29 f0fa
D 50 1234
D 51 0101
E 0040 0008
E 0041 0013
E 0042 2468
E 0043 0102
E 0044 0050
E 0045 2468
E 0046 0101

// ==== compile.f ====
+incdir+common
common/cpu_pkg.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
src/cpu_core.sv
testbench/cpu_assertions.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module cpu_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o cpu_sim
	./obj_dir/cpu_sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
